/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = miner_tb
FLIST       = flist.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_MSG    = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/miner_tb.sv */
// Testbench for the work hasher.
// SHA-256 reference model, host byte transfers and result checks.
`timescale 1ns/1ps

module miner_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int WORK_W       = miner_pkg::WORK_BYTES * 8;
	localparam int GOLDEN_LIMIT = 300;
	localparam int NONCE_WAIT   = 140;
	// Host transfer lengths in clock cycles.
	localparam int WORK_CYCLES  = miner_pkg::WORK_BYTES * 12;
	localparam int READ_CYCLES  = 12 + miner_pkg::RESULT_BYTES * 6;
	// Longest golden wait plus all host transfers and some margin.
	localparam int WATCHDOG_CYCLES =
		((GOLDEN_LIMIT + 2) * NONCE_WAIT + 8 * (WORK_CYCLES + READ_CYCLES)) * 3 / 2;
	// Highest nonce a scan can reach before the watchdog.
	localparam int NONCE_MAX = WATCHDOG_CYCLES / 131;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic rd_clk = 1'b0;
	logic wr_clk = 1'b0;
	logic wr_start = 1'b0;
	miner_pkg::byte_t read = '0;
	miner_pkg::byte_t write;

	int unsigned cycle = 0;
	int unsigned last_byte_cycle;
	int unsigned freeze;
	int pass_count = 0;
	int fail_count = 0;
	int mark = 0;
	logic [WORK_W-1:0] work_a;
	logic [WORK_W-1:0] work_g;
	logic [WORK_W-1:0] work_b;
	logic [95:0] rb;
	logic [95:0] rb_prev;
	miner_pkg::word_t g3;
	logic found;

	miner_top u_miner_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_clk   (rd_clk),
		.read     (read),
		.wr_clk   (wr_clk),
		.wr_start (wr_start),
		.write    (write)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// One SHA-256 compression with word a in the top bits.
	function automatic miner_pkg::state_t compress(input miner_pkg::state_t chain,
			input miner_pkg::block_t blk);
		miner_pkg::word_t w [64];
		miner_pkg::word_t a, b, c, d, e, f, g, h, t1, t2;
		miner_pkg::state_t vars;
		miner_pkg::state_t sum;
		for (int i = 0; i < 16; i++)
			w[i] = blk[511 - 32*i -: 32];
		for (int i = 16; i < 64; i++)
			w[i] = miner_pkg::sha_ssig1(w[i-2]) + w[i-7] + miner_pkg::sha_ssig0(w[i-15]) + w[i-16];
		{a, b, c, d, e, f, g, h} = chain;
		for (int i = 0; i < 64; i++)
		begin
			t1 = h + miner_pkg::sha_bsig1(e) + miner_pkg::sha_ch(e, f, g) + miner_pkg::sha_k[i] + w[i];
			t2 = miner_pkg::sha_bsig0(a) + miner_pkg::sha_maj(a, b, c);
			h = g;
			g = f;
			f = e;
			e = d + t1;
			d = c;
			c = b;
			b = a;
			a = t1 + t2;
		end
		vars = {a, b, c, d, e, f, g, h};
		for (int i = 0; i < 8; i++)
			sum[32*i +: 32] = chain[32*i +: 32] + vars[32*i +: 32];
		return sum;
	endfunction

	// Last word of the double hash for one nonce.
	function automatic miner_pkg::word_t model_hash(input logic [WORK_W-1:0] w,
			input miner_pkg::word_t nonce);
		miner_pkg::state_t d1;
		miner_pkg::state_t d2;
		d1 = compress(w[WORK_W-1:96], {w[95:0], nonce, 32'h8000_0000, 320'd0, 32'd640});
		d2 = compress(miner_pkg::sha_h0, {d1, 32'h8000_0000, 192'd0, 32'd256});
		return d2[31:0];
	endfunction

	function automatic logic is_golden(input miner_pkg::word_t h);
		return h[31 -: miner_pkg::GOLDEN_ZERO_BITS] == '0;
	endfunction

	// First or last golden nonce in 0 to limit.
	function automatic logic golden_search(input logic [WORK_W-1:0] w,
			input miner_pkg::word_t limit, input logic first_only,
			output miner_pkg::word_t nonce);
		logic hit;
		hit = 1'b0;
		nonce = '0;
		for (int unsigned n = 0; n <= limit; n++)
		begin
			if (is_golden(model_hash(w, n)))
			begin
				hit = 1'b1;
				nonce = n;
				if (first_only)
					return 1'b1;
			end
		end
		return hit;
	endfunction

	task automatic check_equal(input string name, input miner_pkg::word_t expected,
			input miner_pkg::word_t actual);
		assert (actual == expected)
			pass_count = pass_count + 1;
		else
		begin
			$display("FAIL %0t %s expected %08h actual %08h", $time, name, expected, actual);
			fail_count = fail_count + 1;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond)
			pass_count = pass_count + 1;
		else
		begin
			$display("Error at %0t: %s", $time, what);
			fail_count = fail_count + 1;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		if (fail_count == mark)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, fail_count - mark);
		mark = fail_count;
	endtask

	// Midstate from a random block and a random tail.
	task automatic make_work(output logic [WORK_W-1:0] w);
		miner_pkg::block_t blk;
		logic [95:0] tail;
		for (int i = 0; i < 16; i++)
			blk[32*i +: 32] = $urandom();
		for (int i = 0; i < 3; i++)
			tail[32*i +: 32] = $urandom();
		w = {compress(miner_pkg::sha_h0, blk), tail};
	endtask

	task automatic send_work(input logic [WORK_W-1:0] w);
		for (int i = 0; i < miner_pkg::WORK_BYTES; i++)
		begin
			@(posedge clk);
			read   <= w[8*i +: 8];
			rd_clk <= ~rd_clk;
			last_byte_cycle = cycle;
			repeat (5) @(posedge clk);
		end
	endtask

	// Bytes land low first in the order golden_nonce, nonce2, hash2.
	task automatic read_result(output logic [95:0] bytes, output int unsigned frozen_at);
		@(posedge clk);
		wr_start <= 1'b1;
		repeat (3) @(posedge clk);
		wr_start <= 1'b0;
		repeat (8) @(posedge clk);
		frozen_at = cycle;
		for (int k = 0; k < miner_pkg::RESULT_BYTES; k++)
		begin
			@(negedge clk);
			bytes[8*k +: 8] = write;
			@(posedge clk);
			wr_clk <= ~wr_clk;
			repeat (5) @(posedge clk);
		end
	endtask

	task automatic check_readback(input logic [WORK_W-1:0] w, input logic [WORK_W-1:0] fb_work,
			input miner_pkg::word_t fb_min, input logic [95:0] bytes);
		miner_pkg::word_t exp_golden;
		logic hit;
		check_equal("hash2", model_hash(w, bytes[63:32]), bytes[95:64]);
		if (bytes[63:32] > NONCE_MAX)
			check_true(1'b0, $sformatf("nonce2 %0d lies beyond any nonce the run can reach",
				bytes[63:32]));
		else
		begin
			hit = golden_search(w, bytes[63:32], 1'b0, exp_golden);
			if (hit)
				check_equal("golden_nonce", exp_golden, bytes[31:0]);
			else
				check_true(is_golden(model_hash(fb_work, bytes[31:0])) && bytes[31:0] >= fb_min,
					$sformatf("golden_nonce %08h is no golden nonce of the earlier work",
					bytes[31:0]));
		end
	endtask

	initial
	begin
		void'($urandom(32'h07fc18b4));

		@(negedge clk);
		check_equal("write", '0, {24'd0, write});
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_equal("write", '0, {24'd0, write});
		read_result(rb, freeze);
		check_equal("golden_nonce", '0, rb[31:0]);
		check_equal("nonce2", '0, rb[63:32]);
		check_equal("hash2", '0, rb[95:64]);
		finish_test(1, "reset state");

		make_work(work_a);
		send_work(work_a);
		repeat (600) @(posedge clk);
		read_result(rb, freeze);
		check_equal("hash2", model_hash(work_a, rb[63:32]), rb[95:64]);
		finish_test(2, "result consistency");

		// Retry until the first golden nonce is close enough.
		found = 1'b0;
		while (!found)
		begin
			make_work(work_g);
			found = golden_search(work_g, GOLDEN_LIMIT - 1, 1'b1, g3);
		end
		send_work(work_g);
		repeat ((g3 + 2) * NONCE_WAIT) @(posedge clk);
		read_result(rb, freeze);
		check_true(rb[63:32] >= g3, $sformatf("nonce2 %0d never reached golden nonce %0d",
			rb[63:32], g3));
		check_readback(work_g, work_g, g3, rb);
		check_true(is_golden(model_hash(work_g, rb[31:0])),
			$sformatf("golden_nonce %08h misses the difficulty rule", rb[31:0]));
		finish_test(3, "golden search");

		make_work(work_b);
		send_work(work_b);
		repeat (400) @(posedge clk);
		read_result(rb, freeze);
		check_true(rb[63:32] <= (freeze - last_byte_cycle) / 131,
			$sformatf("nonce2 %0d too high after %0d cycles, scan did not restart",
			rb[63:32], freeze - last_byte_cycle));
		check_readback(work_b, work_g, g3, rb);
		finish_test(4, "work reload restarts");

		repeat (200) @(posedge clk);
		read_result(rb_prev, freeze);
		check_readback(work_b, work_g, g3, rb_prev);
		repeat (300) @(posedge clk);
		read_result(rb, freeze);
		check_readback(work_b, work_g, g3, rb);
		check_true(rb[63:32] >= rb_prev[63:32],
			$sformatf("nonce2 went back from %0d to %0d", rb_prev[63:32], rb[63:32]));
		finish_test(5, "byte order and freeze");

		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* common/hash_result_if.sv */
// Hash result path from the nonce scanner to the host output side.
`timescale 1ns/1ps

interface hash_result_if;

	miner_pkg::word_t golden_nonce;
	miner_pkg::word_t nonce2;
	miner_pkg::word_t hash2;
	// One cycle per finished nonce.
	logic result_valid;

	modport producer (output golden_nonce, nonce2, hash2, result_valid);
	modport consumer (input golden_nonce, nonce2, hash2, result_valid);

endinterface

/* common/miner_pkg.sv */
// Bitcoin work hasher shared definitions.
// Widths, SHA-256 constants, round functions and host strobe settings.
package miner_pkg;

	typedef logic [31:0]  word_t;
	typedef logic [255:0] state_t;
	typedef logic [511:0] block_t;
	typedef logic [7:0]   byte_t;

	localparam int WORK_BYTES   = 44;
	localparam int RESULT_BYTES = 12;

	// Upper zero bits of the last digest word for a golden nonce.
	localparam int GOLDEN_ZERO_BITS = 8;

	// Host strobe sample chain length.
	localparam int SYNC_DEPTH = 4;

	// Cycles after wr_start while the snapshot keeps reloading.
	localparam logic [2:0] TX_SETTLE = 3'd5;

	localparam word_t sha_k [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Word a sits in the top 32 bits.
	localparam state_t sha_h0 = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	function automatic word_t sha_rotr(word_t x, int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t sha_ch(word_t x, word_t y, word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t sha_maj(word_t x, word_t y, word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

	function automatic word_t sha_bsig0(word_t x);
		return sha_rotr(x, 2) ^ sha_rotr(x, 13) ^ sha_rotr(x, 22);
	endfunction

	function automatic word_t sha_bsig1(word_t x);
		return sha_rotr(x, 6) ^ sha_rotr(x, 11) ^ sha_rotr(x, 25);
	endfunction

	function automatic word_t sha_ssig0(word_t x);
		return sha_rotr(x, 7) ^ sha_rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t sha_ssig1(word_t x);
		return sha_rotr(x, 17) ^ sha_rotr(x, 19) ^ (x >> 10);
	endfunction

	// A host toggle: older samples agree, newest one differs.
	function automatic logic strobe_toggle(logic [SYNC_DEPTH-1:0] s);
		logic [SYNC_DEPTH-2:0] older;
		older = s[SYNC_DEPTH-1:1];
		return ((&older) || !(|older)) && (s[1] != s[0]);
	endfunction

endpackage

/* flist.f */
common/miner_pkg.sv
common/hash_result_if.sv
logic/host_rx.sv
hash_core/sha256_rounds.sv
hash_core/nonce_scanner.sv
logic/host_tx.sv
logic/miner_top.sv
bench/miner_tb.sv

/* hash_core/nonce_scanner.sv */
// Nonce scanner.
// Runs two compressions per nonce and applies the difficulty test.
`timescale 1ns/1ps

module nonce_scanner (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [miner_pkg::WORK_BYTES*8-1:0] work,
	input  logic                                work_load,
	hash_result_if.producer                     res
);

	typedef enum logic [1:0] {IDLE, PASS1, PASS2, COMPARE} scan_state_t;

	scan_state_t       state;
	miner_pkg::word_t  nonce;
	miner_pkg::state_t pass1_digest;
	miner_pkg::state_t chain;
	miner_pkg::block_t block;
	miner_pkg::state_t digest;
	logic start;
	logic done;
	logic pending;
	logic core_busy;
	logic stale;
	logic golden;
	logic chk_armed;
	miner_pkg::word_t chk_nonce;

	// Launch a pass once the core is free.
	assign start  = pending && !core_busy;
	assign golden = (digest[31 -: miner_pkg::GOLDEN_ZERO_BITS] == '0);

	always_comb
	begin
		if (state == PASS2)
		begin
			chain = miner_pkg::sha_h0;
			block = {pass1_digest, 32'h8000_0000, 192'd0, 32'd256};
		end
		else
		begin
			chain = work[miner_pkg::WORK_BYTES*8-1:96];
			block = {work[95:0], nonce, 32'h8000_0000, 320'd0, 32'd640};
		end
	end

	sha256_rounds u_rounds (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.chain_in (chain),
		.block    (block),
		.done     (done),
		.digest   (digest)
	);

	// Mirror of the core's busy flag. An abandoned pass is marked stale.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			core_busy <= 1'b0;
			stale     <= 1'b0;
		end
		else
		begin
			if (start)
				core_busy <= 1'b1;
			else if (done)
				core_busy <= 1'b0;
			if (work_load)
				stale <= (core_busy && !done) || start;
			else if (done)
				stale <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state            <= IDLE;
			nonce            <= '0;
			pending          <= 1'b0;
			res.golden_nonce <= '0;
			res.nonce2       <= '0;
			res.hash2        <= '0;
			res.result_valid <= 1'b0;
		end
		else
		begin
			res.result_valid <= 1'b0;
			if (work_load)
			begin
				state   <= PASS1;
				nonce   <= '0;
				pending <= 1'b1;
			end
			else
			begin
				if (start)
					pending <= 1'b0;
				case (state)
					PASS1:
						if (done && !stale)
						begin
							state   <= PASS2;
							pending <= 1'b1;
						end
					PASS2:
						if (done && !stale)
							state <= COMPARE;
					COMPARE:
					begin
						res.nonce2 <= nonce;
						res.hash2  <= digest[31:0];
						if (golden)
							res.golden_nonce <= nonce;
						res.result_valid <= 1'b1;
						nonce   <= nonce + 32'd1;
						state   <= PASS1;
						pending <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == PASS1 && done && !stale)
			pass1_digest <= digest;
	end

	// Tracks the last reported nonce for the sequence check.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			chk_armed <= 1'b0;
			chk_nonce <= '0;
		end
		else if (work_load)
			chk_armed <= 1'b0;
		else if (res.result_valid)
		begin
			chk_armed <= 1'b1;
			chk_nonce <= res.nonce2;
		end
	end

	a_nonce_step : assert property (@(posedge clk) disable iff (!rst_n)
		res.result_valid && chk_armed |-> res.nonce2 == chk_nonce + 32'd1);

endmodule

/* hash_core/sha256_rounds.sv */
// Iterative SHA-256 compression, one round per clock.
// Compresses one 512-bit block onto the given chaining state.
`timescale 1ns/1ps

module sha256_rounds (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  miner_pkg::state_t chain_in,
	input  miner_pkg::block_t block,
	output logic              done,
	output miner_pkg::state_t digest
);

	miner_pkg::state_t vars;
	miner_pkg::state_t cur_vars;
	miner_pkg::word_t  win [16];
	miner_pkg::word_t  cur_win [16];
	miner_pkg::word_t  a, b, c, d, e, f, g, h;
	miner_pkg::word_t  t1, t2, w_next;
	logic [6:0] round;
	logic busy;
	logic accept;
	logic round_step;

	assign accept     = start && !busy;
	assign round_step = accept || (busy && round != 7'd64);

	// Round 0 works straight from the inputs.
	always_comb
	begin
		cur_vars = busy ? vars : chain_in;
		for (int i = 0; i < 16; i++)
			cur_win[i] = busy ? win[i] : block[511 - 32*i -: 32];
	end

	assign {a, b, c, d, e, f, g, h} = cur_vars;

	assign t1 = h + miner_pkg::sha_bsig1(e) + miner_pkg::sha_ch(e, f, g)
		+ miner_pkg::sha_k[round[5:0]] + cur_win[0];
	assign t2 = miner_pkg::sha_bsig0(a) + miner_pkg::sha_maj(a, b, c);

	// Message schedule word sixteen ahead.
	assign w_next = miner_pkg::sha_ssig1(cur_win[14]) + cur_win[9]
		+ miner_pkg::sha_ssig0(cur_win[1]) + cur_win[0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy  <= 1'b0;
			round <= '0;
			done  <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (accept)
			begin
				busy  <= 1'b1;
				round <= 7'd1;
			end
			else if (busy)
			begin
				if (round == 7'd64)
				begin
					busy  <= 1'b0;
					round <= '0;
					done  <= 1'b1;
				end
				else
					round <= round + 7'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (round_step)
		begin
			vars <= {t1 + t2, a, b, c, d + t1, e, f, g};
			for (int i = 0; i < 15; i++)
				win[i] <= cur_win[i + 1];
			win[15] <= w_next;
		end
		// Final addition onto the chaining state.
		if (busy && round == 7'd64)
			for (int i = 0; i < 8; i++)
				digest[32*i +: 32] <= chain_in[32*i +: 32] + vars[32*i +: 32];
	end

	a_done_latency : assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(accept, 65));

endmodule

/* logic/host_rx.sv */
// Host input side.
// Detects rd_clk toggles and shifts host bytes into the 352-bit work register.
`timescale 1ns/1ps

module host_rx (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                rd_clk,
	input  miner_pkg::byte_t                    read,
	output logic [miner_pkg::WORK_BYTES*8-1:0] work,
	output logic                                work_load
);

	logic [miner_pkg::SYNC_DEPTH-1:0] rd_sync;
	logic [miner_pkg::WORK_BYTES*8-1:0] shadow;
	miner_pkg::byte_t read_q;
	logic rx_toggle;
	logic shift_q;

	assign rx_toggle = miner_pkg::strobe_toggle(rd_sync);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_sync   <= '0;
			shift_q   <= 1'b0;
			work_load <= 1'b0;
		end
		else
		begin
			rd_sync   <= {rd_sync[miner_pkg::SYNC_DEPTH-2:0], rd_clk};
			shift_q   <= rx_toggle;
			// Aligned with the work register update.
			work_load <= shift_q;
		end
	end

	always_ff @(posedge clk)
	begin
		read_q <= read;
		// New byte enters at the top, first byte ends up lowest.
		if (rx_toggle)
			shadow <= {read_q, shadow[miner_pkg::WORK_BYTES*8-1:8]};
		work <= shadow;
	end

	a_load_single : assert property (@(posedge clk) disable iff (!rst_n)
		work_load |=> !work_load);

endmodule

/* logic/host_tx.sv */
// Host output side.
// Freezes a result snapshot on wr_start and shifts it out on wr_clk toggles.
`timescale 1ns/1ps

module host_tx (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr_clk,
	input  logic             wr_start,
	hash_result_if.consumer  res,
	output miner_pkg::byte_t write
);

	logic ws_q1;
	logic ws_q2;
	logic [miner_pkg::SYNC_DEPTH-1:0] wr_sync;
	logic [2:0] settle_cnt;
	logic [miner_pkg::RESULT_BYTES*8-1:0] snap;
	logic tx_toggle;

	assign tx_toggle = miner_pkg::strobe_toggle(wr_sync);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ws_q1      <= 1'b0;
			ws_q2      <= 1'b0;
			wr_sync    <= '0;
			// Counter stays saturated until the first wr_start.
			settle_cnt <= miner_pkg::TX_SETTLE;
			snap       <= '0;
			write      <= '0;
		end
		else
		begin
			ws_q1   <= wr_start;
			ws_q2   <= ws_q1;
			wr_sync <= {wr_sync[miner_pkg::SYNC_DEPTH-2:0], wr_clk};

			if (ws_q2)
				settle_cnt <= '0;
			else if (settle_cnt < miner_pkg::TX_SETTLE)
				settle_cnt <= settle_cnt + 3'd1;

			// Low byte goes out first.
			if (settle_cnt < miner_pkg::TX_SETTLE)
				snap <= {res.hash2, res.nonce2, res.golden_nonce};
			else if (tx_toggle)
				snap <= {8'h00, snap[miner_pkg::RESULT_BYTES*8-1:8]};

			write <= snap[7:0];
		end
	end

endmodule

/* logic/miner_top.sv */
// Bitcoin work hasher top level.
// Host byte ports around a single double SHA-256 nonce scanner.
`timescale 1ns/1ps

module miner_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             rd_clk,
	input  miner_pkg::byte_t read,
	input  logic             wr_clk,
	input  logic             wr_start,
	output miner_pkg::byte_t write
);

	logic [miner_pkg::WORK_BYTES*8-1:0] work;
	logic work_load;

	hash_result_if res_if ();

	host_rx u_host_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_clk    (rd_clk),
		.read      (read),
		.work      (work),
		.work_load (work_load)
	);

	nonce_scanner u_nonce_scanner (
		.clk       (clk),
		.rst_n     (rst_n),
		.work      (work),
		.work_load (work_load),
		.res       (res_if.producer)
	);

	host_tx u_host_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_clk   (wr_clk),
		.wr_start (wr_start),
		.res      (res_if.consumer),
		.write    (write)
	);

endmodule
